// ==== hw/leaf_pkg.sv ====
`default_nettype none

package leaf_pkg;

    //////////////////////////////////////////////////////////////////////
    // Leaf geometry
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_IN_PORTS  = 2;
    localparam int NUM_OUT_PORTS = 3;
    localparam int PAYLOAD_BITS  = 32;

    localparam int LEAF_BITS = 5;
    localparam int PORT_BITS = 4;
    localparam int ADDR_BITS = 7;

    // Destination port that marks a configuration packet
    localparam logic [PORT_BITS-1:0] CFG_PORT = 4'd0;

    //////////////////////////////////////////////////////////////////////
    // Packet format
    //////////////////////////////////////////////////////////////////////

    // Route write carried in the payload of a config packet
    typedef struct packed {
        logic [PORT_BITS-1:0]                          out_port;
        logic [LEAF_BITS-1:0]                          dst_leaf;
        logic [PORT_BITS-1:0]                          dst_port;
        logic [PAYLOAD_BITS-2*PORT_BITS-LEAF_BITS-1:0] pad;
    } route_cfg_t;

    // Same payload word, user data or route write depending on dst_port
    typedef union packed {
        logic [PAYLOAD_BITS-1:0] data;
        route_cfg_t              cfg;
    } leaf_payload_u;

    typedef struct packed {
        logic                 vld;
        logic [LEAF_BITS-1:0] dst_leaf;
        logic [PORT_BITS-1:0] dst_port;
        logic [ADDR_BITS-1:0] addr;
        leaf_payload_u        payload;
    } leaf_pkt_t;

    // One entry per user output stream
    typedef struct packed {
        logic                 valid;
        logic [LEAF_BITS-1:0] dst_leaf;
        logic [PORT_BITS-1:0] dst_port;
    } route_t;

endpackage

`default_nettype wire

// ==== hw/stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fifo import leaf_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr,
    input  logic [PAYLOAD_BITS-1:0] wdata,
    output logic [PAYLOAD_BITS-1:0] rdata,
    output logic                    vld,
    input  logic                    ack
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [PAYLOAD_BITS-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]           wr_ptr;
    logic [AW-1:0]           rd_ptr;
    logic [AW:0]             count;
    logic                    push;
    logic                    pop;

    // Writes into a full FIFO are lost
    assign push = wr && (count != (AW+1)'(FIFO_DEPTH));
    assign pop  = vld && ack;

    assign vld   = (count != '0);
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= wdata;
    end

endmodule

`default_nettype wire

// ==== hw/leaf_ingress.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaf_ingress import leaf_pkg::*; #(
    parameter logic [LEAF_BITS-1:0] LEAF_ID    = 5'd0,
    parameter int                   FIFO_DEPTH = 4
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  leaf_pkt_t                                  din,
    output route_t [NUM_OUT_PORTS-1:0]                 route,
    output logic [NUM_IN_PORTS-1:0][PAYLOAD_BITS-1:0]  in_data,
    output logic [NUM_IN_PORTS-1:0]                    in_vld,
    input  logic [NUM_IN_PORTS-1:0]                    in_ack
);

    logic                    for_us;
    logic                    cfg_hit;
    route_cfg_t              cfg;
    logic [NUM_IN_PORTS-1:0] fifo_wr;

    // Only packets addressed to this leaf are looked at
    assign for_us  = din.vld && (din.dst_leaf == LEAF_ID);
    assign cfg_hit = for_us && (din.dst_port == CFG_PORT);
    assign cfg     = din.payload.cfg;

    //////////////////////////////////////////////////////////////////////
    // Routing table
    //////////////////////////////////////////////////////////////////////

    // out_port is numbered from 1, entry 0 serves output port 1
    always_ff @(posedge clk) begin
        if (rst) begin
            route <= '0;
        end else if (cfg_hit) begin
            for (int j = 0; j < NUM_OUT_PORTS; j++) begin
                if (cfg.out_port == PORT_BITS'(j + 1)) begin
                    route[j].valid    <= 1'b1;
                    route[j].dst_leaf <= cfg.dst_leaf;
                    route[j].dst_port <= cfg.dst_port;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Input stream buffers
    //////////////////////////////////////////////////////////////////////

    genvar i;
    generate
        for (i = 0; i < NUM_IN_PORTS; i++) begin : g_in
            // Network port i+1 feeds user input stream i
            assign fifo_wr[i] = for_us && (din.dst_port == PORT_BITS'(i + 1));

            stream_fifo #(
                .FIFO_DEPTH(FIFO_DEPTH)
            ) stream_fifo_inst (
                .clk  (clk),
                .rst  (rst),
                .wr   (fifo_wr[i]),
                .wdata(din.payload.data),
                .rdata(in_data[i]),
                .vld  (in_vld[i]),
                .ack  (in_ack[i])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hw/leaf_egress.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaf_egress import leaf_pkg::*; (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       resend,
    input  route_t [NUM_OUT_PORTS-1:0]                 route,
    input  logic [NUM_OUT_PORTS-1:0][PAYLOAD_BITS-1:0] out_data,
    input  logic [NUM_OUT_PORTS-1:0]                   out_vld,
    output logic [NUM_OUT_PORTS-1:0]                   out_ack,
    output leaf_pkt_t                                  dout
);

    localparam int PW = $clog2(NUM_OUT_PORTS);

    logic [NUM_OUT_PORTS-1:0] eligible;
    logic [PW-1:0]            last_q;
    logic [PW-1:0]            grant_idx;
    logic                     grant_vld;
    logic                     send;
    logic [ADDR_BITS-1:0]     seq_q [NUM_OUT_PORTS];
    leaf_pkt_t                pkt_d;
    leaf_pkt_t                dout_q;

    // A stream without a route is never picked and stalls the kernel
    always_comb begin
        for (int i = 0; i < NUM_OUT_PORTS; i++) begin
            eligible[i] = out_vld[i] && route[i].valid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Round-robin pick
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [PW-1:0] idx;
        grant_vld = 1'b0;
        grant_idx = '0;
        idx       = last_q;
        // Search starts one past the last granted port
        for (int k = 0; k < NUM_OUT_PORTS; k++) begin
            if (idx == PW'(NUM_OUT_PORTS - 1)) idx = '0;
            else idx = idx + 1'b1;
            if (!grant_vld && eligible[idx]) begin
                grant_vld = 1'b1;
                grant_idx = idx;
            end
        end
    end

    assign send = grant_vld && !resend;

    always_comb begin
        out_ack = '0;
        if (send) out_ack[grant_idx] = 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // Packet build and output register
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        pkt_d = '0;
        if (send) begin
            pkt_d.vld          = 1'b1;
            pkt_d.dst_leaf     = route[grant_idx].dst_leaf;
            pkt_d.dst_port     = route[grant_idx].dst_port;
            pkt_d.addr         = seq_q[grant_idx];
            pkt_d.payload.data = out_data[grant_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_q <= PW'(NUM_OUT_PORTS - 1);
            dout_q <= '0;
            for (int i = 0; i < NUM_OUT_PORTS; i++) seq_q[i] <= '0;
        end else begin
            // Held under resend so the packet gated off is shown afterwards
            if (!resend) dout_q <= pkt_d;
            if (send) begin
                last_q           <= grant_idx;
                seq_q[grant_idx] <= seq_q[grant_idx] + 1'b1;
            end
        end
    end

    assign dout = resend ? '0 : dout_q;

endmodule

`default_nettype wire

// ==== hw/leaf_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaf_interface import leaf_pkg::*; #(
    parameter logic [LEAF_BITS-1:0] LEAF_ID    = 5'd0,
    parameter int                   FIFO_DEPTH = 4
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  leaf_pkt_t                                  din,
    output leaf_pkt_t                                  dout,
    input  logic                                       resend,
    input  logic                                       ap_start,
    output logic [NUM_IN_PORTS-1:0][PAYLOAD_BITS-1:0]  in_data,
    output logic [NUM_IN_PORTS-1:0]                    in_vld,
    input  logic [NUM_IN_PORTS-1:0]                    in_ack,
    input  logic [NUM_OUT_PORTS-1:0][PAYLOAD_BITS-1:0] out_data,
    input  logic [NUM_OUT_PORTS-1:0]                   out_vld,
    output logic [NUM_OUT_PORTS-1:0]                   out_ack,
    output logic                                       kernel_rst
);

    route_t [NUM_OUT_PORTS-1:0] route;
    logic                       run;

    // Kernel stays in reset until the first ap_start
    always_ff @(posedge clk) begin
        if (rst) run <= 1'b0;
        else if (ap_start) run <= 1'b1;
    end

    assign kernel_rst = rst || !run;

    leaf_ingress #(
        .LEAF_ID   (LEAF_ID),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) leaf_ingress_inst (
        .clk    (clk),
        .rst    (rst),
        .din    (din),
        .route  (route),
        .in_data(in_data),
        .in_vld (in_vld),
        .in_ack (in_ack)
    );

    leaf_egress leaf_egress_inst (
        .clk     (clk),
        .rst     (rst),
        .resend  (resend),
        .route   (route),
        .out_data(out_data),
        .out_vld (out_vld),
        .out_ack (out_ack),
        .dout    (dout)
    );

endmodule

`default_nettype wire

// ==== hw/user_kernel.sv ====
`timescale 1ns/1ps
`default_nettype none

module user_kernel import leaf_pkg::*; (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [NUM_IN_PORTS-1:0][PAYLOAD_BITS-1:0]  in_data,
    input  logic [NUM_IN_PORTS-1:0]                    in_vld,
    output logic [NUM_IN_PORTS-1:0]                    in_ack,
    output logic [NUM_OUT_PORTS-1:0][PAYLOAD_BITS-1:0] out_data,
    output logic [NUM_OUT_PORTS-1:0]                   out_vld,
    input  logic [NUM_OUT_PORTS-1:0]                   out_ack
);

    logic                     ready_q;
    logic                     take;
    logic [NUM_OUT_PORTS-1:0] slot_next;

    // ready_q tracks all slots empty, and is low while in reset
    assign take   = (&in_vld) && ready_q;
    assign in_ack = {NUM_IN_PORTS{take}};

    assign slot_next = take ? '1 : (out_vld & ~out_ack);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_vld <= '0;
            ready_q <= 1'b0;
        end else begin
            out_vld <= slot_next;
            ready_q <= ~|slot_next;
        end
    end

    // Slot 0 sum, slot 1 difference, slot 2 XOR
    always_ff @(posedge clk) begin
        if (take) begin
            out_data[0] <= in_data[0] + in_data[1];
            out_data[1] <= in_data[0] - in_data[1];
            out_data[2] <= in_data[0] ^ in_data[1];
        end
    end

endmodule

`default_nettype wire

// ==== hw/leaf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaf_top import leaf_pkg::*; #(
    parameter logic [LEAF_BITS-1:0] LEAF_ID    = 5'd3,
    parameter int                   FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  leaf_pkt_t din,
    output leaf_pkt_t dout,
    input  logic      resend,
    input  logic      ap_start
);

    logic [NUM_IN_PORTS-1:0][PAYLOAD_BITS-1:0]  in_data;
    logic [NUM_IN_PORTS-1:0]                    in_vld;
    logic [NUM_IN_PORTS-1:0]                    in_ack;
    logic [NUM_OUT_PORTS-1:0][PAYLOAD_BITS-1:0] out_data;
    logic [NUM_OUT_PORTS-1:0]                   out_vld;
    logic [NUM_OUT_PORTS-1:0]                   out_ack;
    logic                                       kernel_rst;

    leaf_interface #(
        .LEAF_ID   (LEAF_ID),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) leaf_interface_inst (
        .clk       (clk),
        .rst       (rst),
        .din       (din),
        .dout      (dout),
        .resend    (resend),
        .ap_start  (ap_start),
        .in_data   (in_data),
        .in_vld    (in_vld),
        .in_ack    (in_ack),
        .out_data  (out_data),
        .out_vld   (out_vld),
        .out_ack   (out_ack),
        .kernel_rst(kernel_rst)
    );

    user_kernel user_kernel_inst (
        .clk     (clk),
        .rst     (kernel_rst),
        .in_data (in_data),
        .in_vld  (in_vld),
        .in_ack  (in_ack),
        .out_data(out_data),
        .out_vld (out_vld),
        .out_ack (out_ack)
    );

endmodule

`default_nettype wire

// ==== dv/leaf_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaf_chk import leaf_pkg::*; (
    input logic                       clk,
    input logic                       rst,
    input logic                       resend,
    input route_t [NUM_OUT_PORTS-1:0] route,
    input logic [NUM_OUT_PORTS-1:0]   out_vld,
    input logic [NUM_OUT_PORTS-1:0]   out_ack,
    input leaf_pkt_t                  dout
);

    logic [NUM_OUT_PORTS-1:0] routed;
    int                       fail_count = 0;

    always_comb begin
        for (int i = 0; i < NUM_OUT_PORTS; i++) routed[i] = route[i].valid;
    end

    resend_blanks_dout: assert property (@(posedge clk) disable iff (rst)
        resend |-> (dout == '0))
        else begin
            fail_count++;
            $error("dout carries a packet while resend is high");
        end

    single_ack: assert property (@(posedge clk) disable iff (rst) $onehot0(out_ack))
        else begin
            fail_count++;
            $error("more than one output stream acked in one cycle");
        end

    // An ack needs a waiting word and a route for it
    ack_needs_route: assert property (@(posedge clk) disable iff (rst)
        (out_ack & ~(out_vld & routed)) == '0)
        else begin
            fail_count++;
            $error("output stream acked without vld or without a valid route");
        end

endmodule

bind leaf_egress leaf_chk leaf_chk_inst (
    .clk    (clk),
    .rst    (rst),
    .resend (resend),
    .route  (route),
    .out_vld(out_vld),
    .out_ack(out_ack),
    .dout   (dout)
);

`default_nettype wire

// ==== dv/leaf_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaf_tb import leaf_pkg::*; ();

    localparam logic [LEAF_BITS-1:0] LEAF_ID = 5'd3;
    localparam int                   EW      = ADDR_BITS + PAYLOAD_BITS;

    logic      clk;
    logic      rst;
    leaf_pkt_t din;
    leaf_pkt_t dout;
    logic      resend;
    logic      ap_start;

    // One entry per line of the cases file
    logic [7:0]  op_q [$];
    logic [31:0] f1_q [$];
    logic [31:0] f2_q [$];
    logic [31:0] f3_q [$];

    // Scoreboard entries are {addr, payload} with one queue per output port
    logic [EW-1:0]            exp_q [NUM_OUT_PORTS][$];
    logic [ADDR_BITS-1:0]     seq_exp [NUM_OUT_PORTS];
    logic [LEAF_BITS-1:0]     hdr_leaf [NUM_OUT_PORTS];
    logic [PORT_BITS-1:0]     hdr_port [NUM_OUT_PORTS];
    logic [NUM_OUT_PORTS-1:0] hdr_set;

    logic        started;
    int          value_errors;
    int          other_errors;
    int          assert_errors;
    int          cycle_count;
    int          cycle_limit;

    leaf_top #(
        .LEAF_ID   (LEAF_ID),
        .FIFO_DEPTH(4)
    ) leaf_top_inst (
        .clk     (clk),
        .rst     (rst),
        .din     (din),
        .dout    (dout),
        .resend  (resend),
        .ap_start(ap_start)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    function automatic int packets_pending();
        int n;
        n = 0;
        for (int p = 0; p < NUM_OUT_PORTS; p++) n += exp_q[p].size();
        return n;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic read_cases();
        int          fd;
        int          ch;
        logic [7:0]  op;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        fd = $fopen("dv/leaf_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the cases file dv/leaf_cases.txt");
            other_errors++;
            return;
        end
        while ($fscanf(fd, " %c", op) == 1) begin
            f1 = '0;
            f2 = '0;
            f3 = '0;
            case (op)
                "#": begin
                    // Skip the rest of a comment line
                    do ch = $fgetc(fd); while (ch != 10 && ch != -1);
                end
                "C": void'($fscanf(fd, "%d %d %d", f1, f2, f3));
                "D": void'($fscanf(fd, "%d %h %h", f1, f2, f3));
                "R": void'($fscanf(fd, "%d", f1));
                "X": void'($fscanf(fd, "%d %d %h", f1, f2, f3));
                "S": ;
                default: begin
                    $display("Unknown case letter %c in the cases file", op);
                    other_errors++;
                end
            endcase
            if (op != "#") begin
                op_q.push_back(op);
                f1_q.push_back(f1);
                f2_q.push_back(f2);
                f3_q.push_back(f3);
            end
        end
        $fclose(fd);
    endtask

    task automatic send_packet(input logic [LEAF_BITS-1:0] leaf,
                               input logic [PORT_BITS-1:0] port,
                               input logic [31:0] word);
        @(negedge clk);
        din              = '0;
        din.vld          = 1'b1;
        din.dst_leaf     = leaf;
        din.dst_port     = port;
        din.payload.data = word;
        @(negedge clk);
        din = '0;
    endtask

    // Results leave in pair order, sum on port 1, difference on 2, XOR on 3
    task automatic expect_pair(input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res [NUM_OUT_PORTS];
        res[0] = a + b;
        res[1] = a - b;
        res[2] = a ^ b;
        for (int p = 0; p < NUM_OUT_PORTS; p++) begin
            exp_q[p].push_back({seq_exp[p], res[p]});
            seq_exp[p]++;
        end
    endtask

    task automatic run_case(input logic [7:0] op, input logic [31:0] f1,
                            input logic [31:0] f2, input logic [31:0] f3);
        route_cfg_t  cfg;
        logic [31:0] a;
        logic [31:0] b;
        int          p;
        case (op)
            "C": begin
                p            = int'(f1) - 1;
                cfg          = '0;
                cfg.out_port = f1[PORT_BITS-1:0];
                cfg.dst_leaf = f2[LEAF_BITS-1:0];
                cfg.dst_port = f3[PORT_BITS-1:0];
                if (p >= 0 && p < NUM_OUT_PORTS) begin
                    hdr_leaf[p] = cfg.dst_leaf;
                    hdr_port[p] = cfg.dst_port;
                    hdr_set[p]  = 1'b1;
                end
                send_packet(LEAF_ID, CFG_PORT, cfg);
            end
            "D": begin
                a = (f1 != 0) ? $urandom() : f2;
                b = (f1 != 0) ? $urandom() : f3;
                expect_pair(a, b);
                send_packet(LEAF_ID, 4'd1, a);
                send_packet(LEAF_ID, 4'd2, b);
            end
            "S": begin
                @(negedge clk);
                ap_start = 1'b1;
                started  = 1'b1;
                @(negedge clk);
                ap_start = 1'b0;
            end
            "R": begin
                @(negedge clk);
                resend = 1'b1;
                repeat (f1) @(negedge clk);
                resend = 1'b0;
            end
            "X": send_packet(f1[LEAF_BITS-1:0], f2[PORT_BITS-1:0], f3);
            default: ;
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor and timeout
    //////////////////////////////////////////////////////////////////////

    task automatic take_packet(input leaf_pkt_t pkt);
        int            port;
        logic [EW-1:0] exp;
        port = -1;
        for (int p = 0; p < NUM_OUT_PORTS; p++) begin
            if (hdr_set[p] && pkt.dst_leaf == hdr_leaf[p] && pkt.dst_port == hdr_port[p])
                port = p;
        end
        if (!started) begin
            $display("Packet left the leaf before ap_start");
            other_errors++;
        end else if (port < 0) begin
            $display("Packet with unknown header, leaf %0d port %0d",
                     pkt.dst_leaf, pkt.dst_port);
            other_errors++;
        end else if (exp_q[port].size() == 0) begin
            $display("Extra packet on output port %0d", port + 1);
            other_errors++;
        end else begin
            exp = exp_q[port].pop_front();
            check_value($sformatf("port %0d sequence", port + 1),
                        64'(exp[EW-1:PAYLOAD_BITS]), 64'(pkt.addr));
            check_value($sformatf("port %0d payload", port + 1),
                        64'(exp[PAYLOAD_BITS-1:0]), 64'(pkt.payload.data));
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (resend) check_value("resend gating", 64'(0), 64'(dout));
            if (dout.vld) take_packet(dout);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles with %0d packets still missing",
                     cycle_count, packets_pending());
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        din           = '0;
        resend        = 1'b0;
        ap_start      = 1'b0;
        started       = 1'b0;
        hdr_set       = '0;
        value_errors  = 0;
        other_errors  = 0;
        assert_errors = 0;
        cycle_count   = 0;
        for (int p = 0; p < NUM_OUT_PORTS; p++) seq_exp[p] = '0;
        void'($urandom(32'h2412));
        read_cases();
        cycle_limit = 200 + 40 * op_q.size();

        repeat (2) @(negedge clk);
        rst = 1'b0;

        foreach (op_q[i]) run_case(op_q[i], f1_q[i], f2_q[i], f3_q[i]);
        while (packets_pending() != 0) @(posedge clk);
        // Give stray packets time to show up
        repeat (20) @(posedge clk);

        assert_errors =
            leaf_top_inst.leaf_interface_inst.leaf_egress_inst.leaf_chk_inst.fail_count;
        $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/leaf_cases.txt ====
# C out_port dst_leaf dst_port | D random a b | S | R cycles | X leaf port word
# out_port, leaf, port, cycles and random flag in decimal; a, b and word in hex
C 1 7 2
C 2 9 5
C 3 12 1
D 0 00000005 00000003
D 0 ffffffff 00000001
S
D 0 12345678 0f0f0f0f
D 1 0 0
R 6
D 0 80000000 80000000
X 5 0 1a900000
X 5 1 deadbeef
X 4 2 cafef00d
D 0 00000000 00000001
D 1 0 0
R 3
D 0 a5a5a5a5 5a5a5a5a
D 1 0 0
D 1 0 0

// ==== leaf_top.f ====
hw/leaf_pkg.sv
hw/stream_fifo.sv
hw/leaf_ingress.sv
hw/leaf_egress.sv
hw/leaf_interface.sv
hw/user_kernel.sv
hw/leaf_top.sv
dv/leaf_chk.sv
dv/leaf_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the leaf testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module leaf_tb -f leaf_top.f -o leaf_sim

# Keep running past assertion errors so the testbench can report them
./obj_dir/leaf_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
grep -q "Result: PASSED" sim.log
